/* soc_bus_top.f */
soc_bus_pkg.sv
bus_decode.sv
ram_execute.sv
plic_regs.sv
bus_response.sv
soc_bus_top.sv
soc_bus_props.sv
tb_soc_bus.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert --top-module tb_soc_bus -f soc_bus_top.f \
    -o tb_soc_bus > build.log 2>&1 &&
./obj_dir/tb_soc_bus > sim.log 2>&1
grep -qx "Test completed successfully" sim.log && echo "simulation passed" ||
    { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_soc_bus;

    localparam int done_limit = 20;
    localparam int words_used = 16;

    logic                  CLOCK_50;
    logic                  KEY0;
    soc_bus_pkg::addr_t    bus_address;
    soc_bus_pkg::data_t    bus_write_data;
    soc_bus_pkg::ls_type_t bus_ls_type;
    logic                  bus_read_enable;
    logic                  bus_write_enable;
    soc_bus_pkg::data_t    mtime;
    logic [7:0]            key_ascii;
    logic                  ext_irq;
    soc_bus_pkg::data_t    bus_read_data;
    logic                  bus_read_done;
    logic                  bus_write_done;
    soc_bus_pkg::data_t    mtimecmp;
    logic                  meip_interrupt;
    logic                  msip_interrupt;

    // reference copy of the ram words under test
    logic [31:0] model [];
    logic [31:0] rng;
    int          checks;
    int          errors;

    soc_bus_top u_dut (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // raw lanes sit at bit 0, nbytes wide
    function automatic soc_bus_pkg::data_t expect_load(input soc_bus_pkg::data_t raw,
                                                       input int nbytes, input logic zext);
        soc_bus_pkg::data_t keep;
        soc_bus_pkg::data_t top_bit;
        keep    = (nbytes == 8) ? '1 : ((64'd1 << (8 * nbytes)) - 64'd1);
        top_bit = keep ^ (keep >> 1);
        if (!zext && (raw & top_bit) != '0) begin
            return raw | ~keep;
        end
        return raw & keep;
    endfunction

    function automatic soc_bus_pkg::addr_t ram_addr(input int word, input int off);
        return soc_bus_pkg::ram_base + 64'(4 * word + off);
    endfunction

    task automatic check_value(input string name, input soc_bus_pkg::data_t got,
                               input soc_bus_pkg::data_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        errors++;
    endtask

    // one-cycle enable pulse between two falling edges
    task automatic issue(input logic write, input soc_bus_pkg::addr_t addr,
                         input soc_bus_pkg::ls_type_t ls, input soc_bus_pkg::data_t wdata);
        bus_address      = addr;
        bus_ls_type      = ls;
        bus_write_data   = wdata;
        bus_read_enable  = !write;
        bus_write_enable = write;
        @(negedge CLOCK_50);
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
    endtask

    task automatic finish_access(input logic write, input int exp_edges);
        int edges;
        edges = 1;
        while (!(write ? bus_write_done : bus_read_done) && edges < done_limit) begin
            @(negedge CLOCK_50);
            edges++;
        end
        if (!(write ? bus_write_done : bus_read_done)) begin
            report_timeout("bus done flag did not come back high");
        end else begin
            checks++;
            assert (edges == exp_edges) else begin
                $display("access at %h ended after %0d edges instead of %0d",
                         bus_address, edges, exp_edges);
                errors++;
            end
        end
    endtask

    task automatic write_bus(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::ls_type_t ls,
                             input soc_bus_pkg::data_t data, input int exp_edges);
        issue(1'b1, addr, ls, data);
        finish_access(1'b1, exp_edges);
    endtask

    task automatic read_expect(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::ls_type_t ls,
                               input soc_bus_pkg::data_t exp, input int exp_edges);
        issue(1'b0, addr, ls, '0);
        finish_access(1'b0, exp_edges);
        check_value("bus_read_data", bus_read_data, exp);
    endtask

    task automatic wait_interrupt(input logic ctx);
        int cycles;
        cycles = 0;
        while (!(ctx ? msip_interrupt : meip_interrupt) && cycles < done_limit) begin
            @(negedge CLOCK_50);
            cycles++;
        end
        if (!(ctx ? msip_interrupt : meip_interrupt)) begin
            report_timeout("interrupt output did not rise after ext_irq");
        end
    endtask

    initial begin
        soc_bus_pkg::data_t d;
        soc_bus_pkg::data_t raw;
        logic [31:0]        en_val [2];
        logic [2:0]         th_val [2];
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = soc_bus_pkg::ls_w;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        mtime            = 64'h0123_4567_89AB_CDEF;
        key_ascii        = 8'hC5;
        ext_irq          = 1'b0;
        checks           = 0;
        errors           = 0;
        rng              = 32'hbcb6f6b4;
        model            = new[words_used];
        repeat (8) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);

        check_value("{read_done, write_done, meip, msip}",
                    {60'd0, bus_read_done, bus_write_done, meip_interrupt, msip_interrupt},
                    64'hC);
        check_value("mtimecmp", mtimecmp, 64'h8000_0000);

        // words, then doublewords over the low half
        for (int i = 0; i < words_used; i++) begin
            rng = xorshift(rng);
            model[i] = rng;
            write_bus(ram_addr(i, 0), soc_bus_pkg::ls_w, {~rng, rng}, 2);
        end
        for (int i = 0; i < words_used / 4; i++) begin
            rng = xorshift(rng);
            d[31:0] = rng;
            rng = xorshift(rng);
            d[63:32] = rng;
            model[2 * i]     = d[31:0];
            model[2 * i + 1] = d[63:32];
            write_bus(ram_addr(2 * i, 0), soc_bus_pkg::ls_d, d, 3);
        end
        for (int i = 0; i < words_used; i++) begin
            raw = {32'd0, model[i]};
            read_expect(ram_addr(i, 0), soc_bus_pkg::ls_w, expect_load(raw, 4, 1'b0), 2);
            read_expect(ram_addr(i, 0), soc_bus_pkg::ls_wu, expect_load(raw, 4, 1'b1), 2);
        end
        for (int i = 0; i < words_used / 2; i++) begin
            read_expect(ram_addr(2 * i, 0), soc_bus_pkg::ls_d,
                        {model[2 * i + 1], model[2 * i]}, 3);
        end

        // byte lanes in word 12, halfword lanes in word 13
        for (int off = 0; off < 4; off++) begin
            rng = xorshift(rng);
            model[12] = (model[12] & ~(32'hFF << (8 * off))) | ({24'd0, rng[7:0]} << (8 * off));
            write_bus(ram_addr(12, off), soc_bus_pkg::ls_b, {32'd0, rng}, 2);
        end
        for (int off = 0; off < 4; off += 2) begin
            rng = xorshift(rng);
            model[13] = (model[13] & ~(32'hFFFF << (8 * off))) |
                        ({16'd0, rng[15:0]} << (8 * off));
            write_bus(ram_addr(13, off), soc_bus_pkg::ls_h, {32'd0, rng}, 2);
        end
        for (int w = 12; w < 14; w++) begin
            for (int off = 0; off < 4; off++) begin
                raw = {32'd0, model[w]} >> (8 * off);
                read_expect(ram_addr(w, off), soc_bus_pkg::ls_b, expect_load(raw, 1, 1'b0), 2);
                read_expect(ram_addr(w, off), soc_bus_pkg::ls_bu, expect_load(raw, 1, 1'b1), 2);
                if (off % 2 == 0) begin
                    read_expect(ram_addr(w, off), soc_bus_pkg::ls_h,
                                expect_load(raw, 2, 1'b0), 2);
                    read_expect(ram_addr(w, off), soc_bus_pkg::ls_hu,
                                expect_load(raw, 2, 1'b1), 2);
                end
            end
        end

        // timer and keyboard
        rng = xorshift(rng);
        d = {rng, ~rng};
        write_bus(soc_bus_pkg::mtimecmp_addr, soc_bus_pkg::ls_d, d, 2);
        check_value("mtimecmp", mtimecmp, d);
        read_expect(soc_bus_pkg::mtimecmp_addr, soc_bus_pkg::ls_d, d, 2);
        read_expect(soc_bus_pkg::mtime_addr, soc_bus_pkg::ls_d, mtime, 2);
        read_expect(soc_bus_pkg::key_base, soc_bus_pkg::ls_d, {56'd0, key_ascii}, 2);

        // plic registers of both contexts are written before either is read back
        for (int c = 0; c < 2; c++) begin
            rng = xorshift(rng);
            en_val[c] = rng;
            th_val[c] = {rng[2:1], 1'(c)};
            d = soc_bus_pkg::plic_enable_addr + 64'(c) * soc_bus_pkg::plic_ctx_enable_stride;
            write_bus(d, soc_bus_pkg::ls_w, {32'd0, en_val[c]}, 2);
            d = soc_bus_pkg::plic_threshold_addr + 64'(c) * soc_bus_pkg::plic_ctx_reg_stride;
            write_bus(d, soc_bus_pkg::ls_w, {61'd0, th_val[c]}, 2);
        end
        for (int c = 0; c < 2; c++) begin
            d = soc_bus_pkg::plic_enable_addr + 64'(c) * soc_bus_pkg::plic_ctx_enable_stride;
            read_expect(d, soc_bus_pkg::ls_d, {32'd0, en_val[c]}, 2);
            d = soc_bus_pkg::plic_threshold_addr + 64'(c) * soc_bus_pkg::plic_ctx_reg_stride;
            read_expect(d, soc_bus_pkg::ls_d, {61'd0, th_val[c]}, 2);
        end

        // context 0 takes source 1
        write_bus(soc_bus_pkg::plic_enable_addr, soc_bus_pkg::ls_w, 64'h2, 2);
        write_bus(soc_bus_pkg::plic_enable_addr + soc_bus_pkg::plic_ctx_enable_stride,
                  soc_bus_pkg::ls_w, 64'h0, 2);
        ext_irq = 1'b1;
        wait_interrupt(1'b0);
        check_value("msip_interrupt", 64'(msip_interrupt), 64'd0);
        read_expect(soc_bus_pkg::plic_claim_addr, soc_bus_pkg::ls_d, 64'd1, 2);
        check_value("meip_interrupt", 64'(meip_interrupt), 64'd0);
        ext_irq = 1'b0;

        // context 1 takes source 1
        write_bus(soc_bus_pkg::plic_enable_addr, soc_bus_pkg::ls_w, 64'h0, 2);
        write_bus(soc_bus_pkg::plic_enable_addr + soc_bus_pkg::plic_ctx_enable_stride,
                  soc_bus_pkg::ls_w, 64'h2, 2);
        ext_irq = 1'b1;
        wait_interrupt(1'b1);
        check_value("meip_interrupt", 64'(meip_interrupt), 64'd0);
        read_expect(soc_bus_pkg::plic_claim_addr + soc_bus_pkg::plic_ctx_reg_stride,
                    soc_bus_pkg::ls_d, 64'd1, 2);
        check_value("msip_interrupt", 64'(msip_interrupt), 64'd0);
        ext_irq = 1'b0;

        // source pending but enabled nowhere
        write_bus(soc_bus_pkg::plic_enable_addr + soc_bus_pkg::plic_ctx_enable_stride,
                  soc_bus_pkg::ls_w, 64'h0, 2);
        ext_irq = 1'b1;
        repeat (2) @(negedge CLOCK_50);
        read_expect(soc_bus_pkg::plic_pending_addr, soc_bus_pkg::ls_d, 64'h2, 2);
        read_expect(soc_bus_pkg::plic_claim_addr, soc_bus_pkg::ls_d, 64'd0, 2);
        read_expect(soc_bus_pkg::plic_claim_addr + soc_bus_pkg::plic_ctx_reg_stride,
                    soc_bus_pkg::ls_d, 64'd0, 2);
        check_value("{meip, msip}", {62'd0, meip_interrupt, msip_interrupt}, 64'd0);
        ext_irq = 1'b0;

        read_expect(64'h3000_0000, soc_bus_pkg::ls_d, 64'd0, 2);

        errors += int'(u_dut.u_props.failures);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* soc_bus_props.sv */
`timescale 1ns/1ps

module soc_bus_props #(
    parameter int RAM_WORDS = 2048
) (
    input logic                  CLOCK_50,
    input logic                  KEY0,
    input soc_bus_pkg::addr_t    bus_address,
    input soc_bus_pkg::ls_type_t bus_ls_type,
    input logic                  bus_read_enable,
    input logic                  bus_write_enable,
    input logic                  bus_read_done,
    input logic                  bus_write_done,
    input logic                  ext_irq,
    input logic                  meip_interrupt,
    input logic                  msip_interrupt
);

    int unsigned failures = 0;
    logic        ram_double;

    // ld and sd to the ram take one extra cycle
    assign ram_double = bus_ls_type == soc_bus_pkg::ls_d &&
                        bus_address >= soc_bus_pkg::ram_base &&
                        bus_address < soc_bus_pkg::ram_base + 64'(4 * RAM_WORDS);

    one_enable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable))
        else begin
            $error("read and write enable high in the same cycle");
            failures++;
        end

    read_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_enable && !ram_double |=> !bus_read_done ##1 bus_read_done)
        else begin
            $error("read done did not fall and rise over two edges");
            failures++;
        end

    read_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_enable && ram_double |=> !bus_read_done [*2] ##1 bus_read_done)
        else begin
            $error("ld done did not fall and rise over three edges");
            failures++;
        end

    write_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable && !ram_double |=> !bus_write_done ##1 bus_write_done)
        else begin
            $error("write done did not fall and rise over two edges");
            failures++;
        end

    write_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable && ram_double |=> !bus_write_done [*2] ##1 bus_write_done)
        else begin
            $error("sd done did not fall and rise over three edges");
            failures++;
        end

    // an interrupt needs a new ext_irq edge or an enable write behind it
    irq_cause: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(meip_interrupt) || $rose(msip_interrupt) |->
            $past(ext_irq) || !$past(bus_write_done))
        else begin
            $error("interrupt rose without ext_irq or a bus write");
            failures++;
        end

endmodule

bind soc_bus_top soc_bus_props #(
    .RAM_WORDS(RAM_WORDS)
) u_props (
    .CLOCK_50        (CLOCK_50),
    .KEY0            (KEY0),
    .bus_address     (bus_address),
    .bus_ls_type     (bus_ls_type),
    .bus_read_enable (bus_read_enable),
    .bus_write_enable(bus_write_enable),
    .bus_read_done   (bus_read_done),
    .bus_write_done  (bus_write_done),
    .ext_irq         (ext_irq),
    .meip_interrupt  (meip_interrupt),
    .msip_interrupt  (msip_interrupt)
);

/* soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int RAM_WORDS = 2048
) (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  soc_bus_pkg::addr_t    bus_address,
    input  soc_bus_pkg::data_t    bus_write_data,
    input  soc_bus_pkg::ls_type_t bus_ls_type,
    input  logic                 bus_read_enable,
    input  logic                 bus_write_enable,
    input  soc_bus_pkg::data_t    mtime,
    input  logic [7:0]           key_ascii,
    input  logic                 ext_irq,
    output soc_bus_pkg::data_t    bus_read_data,
    output logic                 bus_read_done,
    output logic                 bus_write_done,
    output soc_bus_pkg::data_t    mtimecmp,
    output logic                 meip_interrupt,
    output logic                 msip_interrupt
);

    // captured request, shared by all execute units
    logic                  req_valid;
    logic                  req_write;
    soc_bus_pkg::region_t  req_region;
    soc_bus_pkg::addr_t    req_addr;
    soc_bus_pkg::ls_type_t req_ls_type;
    soc_bus_pkg::data_t    req_wdata;

    soc_bus_pkg::data_t ram_rdata;
    logic               ram_done;
    soc_bus_pkg::data_t plic_rdata;

    bus_decode #(
        .RAM_WORDS(RAM_WORDS)
    ) u_decode (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_address     (bus_address),
        .bus_write_data  (bus_write_data),
        .bus_ls_type     (bus_ls_type),
        .bus_read_enable (bus_read_enable),
        .bus_write_enable(bus_write_enable),
        .req_valid       (req_valid),
        .req_write       (req_write),
        .req_region      (req_region),
        .req_addr        (req_addr),
        .req_ls_type     (req_ls_type),
        .req_wdata       (req_wdata)
    );

    ram_execute #(
        .RAM_WORDS(RAM_WORDS)
    ) u_ram (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_region (req_region),
        .req_addr   (req_addr),
        .req_ls_type(req_ls_type),
        .req_wdata  (req_wdata),
        .ram_rdata  (ram_rdata),
        .ram_done   (ram_done)
    );

    plic_regs u_plic (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .ext_irq       (ext_irq),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_region    (req_region),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .plic_rdata    (plic_rdata),
        .meip_interrupt(meip_interrupt),
        .msip_interrupt(msip_interrupt)
    );

    bus_response u_resp (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_read_enable (bus_read_enable),
        .bus_write_enable(bus_write_enable),
        .req_valid       (req_valid),
        .req_write       (req_write),
        .req_region      (req_region),
        .req_ls_type     (req_ls_type),
        .req_wdata       (req_wdata),
        .ram_rdata       (ram_rdata),
        .ram_done        (ram_done),
        .plic_rdata      (plic_rdata),
        .mtime           (mtime),
        .key_ascii       (key_ascii),
        .bus_read_data   (bus_read_data),
        .bus_read_done   (bus_read_done),
        .bus_write_done  (bus_write_done),
        .mtimecmp        (mtimecmp)
    );

endmodule

/* bus_response.sv */
`timescale 1ns/1ps

module bus_response (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  bus_read_enable,
    input  logic                  bus_write_enable,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  soc_bus_pkg::region_t  req_region,
    input  soc_bus_pkg::ls_type_t req_ls_type,
    input  soc_bus_pkg::data_t    req_wdata,
    input  soc_bus_pkg::data_t    ram_rdata,
    input  logic                  ram_done,
    input  soc_bus_pkg::data_t    plic_rdata,
    input  soc_bus_pkg::data_t    mtime,
    input  logic [7:0]            key_ascii,
    output soc_bus_pkg::data_t    bus_read_data,
    output logic                  bus_read_done,
    output logic                  bus_write_done,
    output soc_bus_pkg::data_t    mtimecmp
);

    logic               access_end;
    soc_bus_pkg::data_t mmio_value;
    soc_bus_pkg::data_t read_value;

    // ram reports its own end, every other region ends with the request
    assign access_end = ram_done ||
                        (req_valid && req_region != soc_bus_pkg::region_ram);

    always_comb begin
        case (req_region)
            soc_bus_pkg::region_key:      mmio_value = {56'd0, key_ascii};
            soc_bus_pkg::region_mtime:    mmio_value = mtime;
            soc_bus_pkg::region_mtimecmp: mmio_value = mtimecmp;
            soc_bus_pkg::region_plic_priority,
            soc_bus_pkg::region_plic_pending,
            soc_bus_pkg::region_plic_enable,
            soc_bus_pkg::region_plic_threshold,
            soc_bus_pkg::region_plic_claim: mmio_value = plic_rdata;
            default:                      mmio_value = '0;
        endcase
    end

    // mmio registers are sized like a load from offset zero
    assign read_value = (req_region == soc_bus_pkg::region_ram) ? ram_rdata
                        : soc_bus_pkg::load_extend(mmio_value, req_ls_type);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
            mtimecmp       <= soc_bus_pkg::mtimecmp_reset;
        end else begin
            if (bus_read_enable) begin
                bus_read_done <= 1'b0;
            end
            if (bus_write_enable) begin
                bus_write_done <= 1'b0;
            end
            if (access_end) begin
                if (req_write) begin
                    bus_write_done <= 1'b1;
                end else begin
                    bus_read_done <= 1'b1;
                    bus_read_data <= read_value;
                end
            end
            if (req_valid && req_write && req_region == soc_bus_pkg::region_mtimecmp) begin
                mtimecmp <= req_wdata;
            end
        end
    end

endmodule

/* plic_regs.sv */
`timescale 1ns/1ps

module plic_regs (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 ext_irq,
    input  logic                 req_valid,
    input  logic                 req_write,
    input  soc_bus_pkg::region_t req_region,
    input  soc_bus_pkg::addr_t   req_addr,
    input  soc_bus_pkg::data_t   req_wdata,
    output soc_bus_pkg::data_t   plic_rdata,
    output logic                 meip_interrupt,
    output logic                 msip_interrupt
);

    logic [2:0]  priority_q [soc_bus_pkg::plic_sources];
    logic [31:0] pending;
    logic [31:0] enable_q [2];
    logic [2:0]  threshold_q [2];
    logic        irq_q;

    logic [2:0] prio_idx;
    logic       ctx_en;
    logic       ctx_reg;
    logic [4:0] claim_id [2];

    assign prio_idx = 3'((req_addr - soc_bus_pkg::plic_base) >> 2);

    // which context the captured address names
    assign ctx_en  = req_addr == soc_bus_pkg::plic_enable_addr +
                                 soc_bus_pkg::plic_ctx_enable_stride;
    assign ctx_reg = (req_addr == soc_bus_pkg::plic_threshold_addr +
                                  soc_bus_pkg::plic_ctx_reg_stride) ||
                     (req_addr == soc_bus_pkg::plic_claim_addr +
                                  soc_bus_pkg::plic_ctx_reg_stride);

    // only source 1 is wired, priority is not compared
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            claim_id[c] = (pending[1] && enable_q[c][1]) ? 5'd1 : 5'd0;
        end
    end

    assign meip_interrupt = claim_id[0] != 5'd0;
    assign msip_interrupt = claim_id[1] != 5'd0;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < soc_bus_pkg::plic_sources; i++) begin
                priority_q[i] <= 3'd0;
            end
            pending        <= 32'd0;
            enable_q[0]    <= 32'd0;
            enable_q[1]    <= 32'd0;
            threshold_q[0] <= 3'd0;
            threshold_q[1] <= 3'd0;
            irq_q          <= 1'b0;
        end else begin
            irq_q <= ext_irq;
            if (ext_irq && !irq_q) begin
                pending[1] <= 1'b1;
            end
            if (req_valid && req_write) begin
                case (req_region)
                    soc_bus_pkg::region_plic_priority:  priority_q[prio_idx] <= req_wdata[2:0];
                    soc_bus_pkg::region_plic_enable:    enable_q[ctx_en] <= req_wdata[31:0];
                    soc_bus_pkg::region_plic_threshold: threshold_q[ctx_reg] <= req_wdata[2:0];
                    default: ;
                endcase
            end
            // claim read completes the interrupt, later than the capture above
            if (req_valid && !req_write && req_region == soc_bus_pkg::region_plic_claim &&
                claim_id[ctx_reg] != 5'd0) begin
                pending[claim_id[ctx_reg]] <= 1'b0;
            end
        end
    end

    always_comb begin
        case (req_region)
            soc_bus_pkg::region_plic_priority:  plic_rdata = {61'd0, priority_q[prio_idx]};
            soc_bus_pkg::region_plic_pending:   plic_rdata = {32'd0, pending};
            soc_bus_pkg::region_plic_enable:    plic_rdata = {32'd0, enable_q[ctx_en]};
            soc_bus_pkg::region_plic_threshold: plic_rdata = {61'd0, threshold_q[ctx_reg]};
            soc_bus_pkg::region_plic_claim:     plic_rdata = {59'd0, claim_id[ctx_reg]};
            default:                            plic_rdata = '0;
        endcase
    end

endmodule

/* ram_execute.sv */
`timescale 1ns/1ps

module ram_execute #(
    parameter int RAM_WORDS = 2048
) (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  soc_bus_pkg::region_t  req_region,
    input  soc_bus_pkg::addr_t    req_addr,
    input  soc_bus_pkg::ls_type_t req_ls_type,
    input  soc_bus_pkg::data_t    req_wdata,
    output soc_bus_pkg::data_t    ram_rdata,
    output logic                  ram_done
);

    localparam int idx_w = $clog2(RAM_WORDS);

    logic [31:0] mem [RAM_WORDS];

    logic             ram_req;
    logic             is_double;
    logic [idx_w-1:0] idx;
    logic [idx_w-1:0] hi_idx;
    logic [1:0]       off;
    logic [31:0]      word_rd;
    logic [31:0]      word_shifted;
    logic [31:0]      wmask;
    logic [31:0]      wshifted;
    logic             beat_q;
    logic [31:0]      lo_q;

    assign ram_req   = req_valid && req_region == soc_bus_pkg::region_ram;
    assign is_double = req_ls_type == soc_bus_pkg::ls_d;
    assign idx       = req_addr[2 +: idx_w];
    assign hi_idx    = idx + 1'b1;
    assign off       = req_addr[1:0];

    assign word_rd      = mem[idx];
    assign word_shifted = word_rd >> {off, 3'b000};

    // byte lanes touched by a store
    always_comb begin
        case (req_ls_type[1:0])
            2'b00:   wmask = 32'h0000_00FF << {off, 3'b000};
            2'b01:   wmask = 32'h0000_FFFF << {off[1], 4'b0000};
            default: wmask = 32'hFFFF_FFFF;
        endcase
        wshifted = req_wdata[31:0] << {off, 3'b000};
    end

    // second beat of ld or sd follows the first
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat_q <= 1'b0;
        end else begin
            beat_q <= ram_req && is_double;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_req && req_write) begin
            mem[idx] <= (word_rd & ~wmask) | (wshifted & wmask);
        end
        // high word of sd lands in the next word
        if (beat_q && req_write) begin
            mem[hi_idx] <= req_wdata[63:32];
        end
        if (ram_req) begin
            lo_q <= word_rd;
        end
    end

    // word access ends with its request, doubleword one cycle later
    assign ram_done = (ram_req && !is_double) || beat_q;

    assign ram_rdata = beat_q ? {mem[hi_idx], lo_q}
                              : soc_bus_pkg::load_extend({32'b0, word_shifted}, req_ls_type);

endmodule

/* bus_decode.sv */
`timescale 1ns/1ps

module bus_decode #(
    parameter int RAM_WORDS = 2048
) (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  soc_bus_pkg::addr_t    bus_address,
    input  soc_bus_pkg::data_t    bus_write_data,
    input  soc_bus_pkg::ls_type_t bus_ls_type,
    input  logic                  bus_read_enable,
    input  logic                  bus_write_enable,
    output logic                  req_valid,
    output logic                  req_write,
    output soc_bus_pkg::region_t  req_region,
    output soc_bus_pkg::addr_t    req_addr,
    output soc_bus_pkg::ls_type_t req_ls_type,
    output soc_bus_pkg::data_t    req_wdata
);

    localparam soc_bus_pkg::addr_t ram_end = soc_bus_pkg::ram_base + 64'(4 * RAM_WORDS);
    localparam soc_bus_pkg::addr_t prio_end =
        soc_bus_pkg::plic_base + 64'(4 * soc_bus_pkg::plic_sources);

    soc_bus_pkg::region_t region;

    // classify the live bus address
    always_comb begin
        region = soc_bus_pkg::region_none;
        if (bus_address >= soc_bus_pkg::ram_base && bus_address < ram_end) begin
            region = soc_bus_pkg::region_ram;
        end else if (bus_address == soc_bus_pkg::key_base) begin
            region = soc_bus_pkg::region_key;
        end else if (bus_address == soc_bus_pkg::mtime_addr) begin
            region = soc_bus_pkg::region_mtime;
        end else if (bus_address == soc_bus_pkg::mtimecmp_addr) begin
            region = soc_bus_pkg::region_mtimecmp;
        end else if (bus_address >= soc_bus_pkg::plic_base && bus_address < prio_end) begin
            region = soc_bus_pkg::region_plic_priority;
        end else if (bus_address == soc_bus_pkg::plic_pending_addr) begin
            region = soc_bus_pkg::region_plic_pending;
        end else if (bus_address == soc_bus_pkg::plic_enable_addr ||
                     bus_address == soc_bus_pkg::plic_enable_addr +
                                    soc_bus_pkg::plic_ctx_enable_stride) begin
            region = soc_bus_pkg::region_plic_enable;
        end else if (bus_address == soc_bus_pkg::plic_threshold_addr ||
                     bus_address == soc_bus_pkg::plic_threshold_addr +
                                    soc_bus_pkg::plic_ctx_reg_stride) begin
            region = soc_bus_pkg::region_plic_threshold;
        end else if (bus_address == soc_bus_pkg::plic_claim_addr ||
                     bus_address == soc_bus_pkg::plic_claim_addr +
                                    soc_bus_pkg::plic_ctx_reg_stride) begin
            region = soc_bus_pkg::region_plic_claim;
        end
    end

    // control part of the request
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            req_valid  <= 1'b0;
            req_write  <= 1'b0;
            req_region <= soc_bus_pkg::region_none;
        end else begin
            req_valid <= bus_read_enable | bus_write_enable;
            if (bus_read_enable | bus_write_enable) begin
                req_write  <= bus_write_enable;
                req_region <= region;
            end
        end
    end

    // payload is held until the next request
    always_ff @(posedge CLOCK_50) begin
        if (bus_read_enable | bus_write_enable) begin
            req_addr    <= bus_address;
            req_ls_type <= bus_ls_type;
            req_wdata   <= bus_write_data;
        end
    end

endmodule

/* soc_bus_pkg.sv */
package soc_bus_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] addr_t;
    typedef logic [xlen-1:0] data_t;

    // target of a decoded bus request
    typedef enum logic [3:0] {
        region_none,
        region_ram,
        region_key,
        region_mtime,
        region_mtimecmp,
        region_plic_priority,
        region_plic_pending,
        region_plic_enable,
        region_plic_threshold,
        region_plic_claim
    } region_t;

    // bit 2 marks an unsigned load, stores use the low four codes
    typedef enum logic [2:0] {
        ls_b  = 3'b000,
        ls_h  = 3'b001,
        ls_w  = 3'b010,
        ls_d  = 3'b011,
        ls_bu = 3'b100,
        ls_hu = 3'b101,
        ls_wu = 3'b110
    } ls_type_t;

    // address map
    localparam addr_t ram_base            = 64'h0000_0000_1000_0000;
    localparam addr_t key_base            = 64'h0000_0000_2000_0000;
    localparam addr_t mtime_addr          = 64'h0000_0000_0200_BFF8;
    localparam addr_t mtimecmp_addr       = 64'h0000_0000_0200_4000;
    localparam addr_t plic_base           = 64'h0000_0000_0C00_0000;
    localparam addr_t plic_pending_addr   = plic_base + 64'h1000;
    localparam addr_t plic_enable_addr    = plic_base + 64'h2000;
    localparam addr_t plic_threshold_addr = plic_base + 64'h20_0000;
    localparam addr_t plic_claim_addr     = plic_base + 64'h20_0004;

    // spacing between context 0 and context 1
    localparam addr_t plic_ctx_enable_stride = 64'h80;
    localparam addr_t plic_ctx_reg_stride    = 64'h1000;

    localparam int plic_sources = 6;

    localparam data_t mtimecmp_reset = 64'h0000_0000_8000_0000;

    // size and extend a value that sits at bit 0, as a load would see it
    function automatic data_t load_extend(input data_t raw, input ls_type_t ls);
        case (ls)
            ls_b:    load_extend = {{56{raw[7]}}, raw[7:0]};
            ls_h:    load_extend = {{48{raw[15]}}, raw[15:0]};
            ls_w:    load_extend = {{32{raw[31]}}, raw[31:0]};
            ls_bu:   load_extend = {56'b0, raw[7:0]};
            ls_hu:   load_extend = {48'b0, raw[15:0]};
            ls_wu:   load_extend = {32'b0, raw[31:0]};
            default: load_extend = raw;
        endcase
    endfunction

endpackage
